// ==== files.f ====
src/rv_div_op_pkg.sv
src/div_core_pkg.sv
src/div_operand_prep.sv
src/div_radix4_core.sv
src/div_result_fixup.sv
src/div_unit.sv
testbench/div_unit_properties.sv
testbench/div_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the divide unit testbench with Verilator, from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module div_unit_tb \
  -f files.f \
  -o div_unit_sim

# a fatal stop returns non-zero, the output decides
output=$(./obj_dir/div_unit_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Test completed successfully"; then
  exit 0
else
  exit 1
fi

// ==== src/div_core_pkg.sv ====
// datapath types for the unsigned core; struct widths are fixed at the register width
package div_core_pkg;

  // magnitude width seen by the core
  localparam int unsigned dp_width = rv_div_op_pkg::xlen;

  // ------------------------------------------------------------
  // core command and result
  // ------------------------------------------------------------
  // unsigned magnitudes only
  typedef struct packed {
    logic [dp_width-1:0] dividend;
    logic [dp_width-1:0] divisor;
  } div_cmd_t;

  typedef struct packed {
    logic [dp_width-1:0] quotient;
    logic [dp_width-1:0] remainder;
  } div_core_out_t;

  // ------------------------------------------------------------
  // core sequencing
  // ------------------------------------------------------------
  // DONE lasts exactly one cycle
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } core_state_e;

endpackage

// ==== src/div_operand_prep.sv ====
// request decode; no back-pressure, a request while busy or with op NONE is ignored
`timescale 1ns/1ps

module div_operand_prep (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_valid,
  input  rv_div_op_pkg::div_req_t  req,
  input  logic                     fake,
  input  logic                     busy,
  output logic                     cmd_valid,
  output div_core_pkg::div_cmd_t   cmd,
  output rv_div_op_pkg::div_fix_t  fix,
  output logic                     fake_ack
);

  localparam int unsigned xlen = rv_div_op_pkg::xlen;
  localparam int unsigned half = rv_div_op_pkg::half;

  logic            signed_op;
  logic            word_op;
  logic            rem_op;
  logic [xlen-1:0] a_ext;
  logic [xlen-1:0] b_ext;
  logic            a_neg;
  logic            b_neg;

  // ------------------------------------------------------------
  // opcode classes
  // ------------------------------------------------------------
  always_comb begin
    signed_op = 1'b0;
    word_op   = 1'b0;
    rem_op    = 1'b0;
    case (req.op)
      rv_div_op_pkg::DIV:   signed_op = 1'b1;
      rv_div_op_pkg::REM: begin
        signed_op = 1'b1;
        rem_op    = 1'b1;
      end
      rv_div_op_pkg::REMU:  rem_op = 1'b1;
      rv_div_op_pkg::DIVW: begin
        signed_op = 1'b1;
        word_op   = 1'b1;
      end
      rv_div_op_pkg::DIVUW: word_op = 1'b1;
      rv_div_op_pkg::REMW: begin
        signed_op = 1'b1;
        word_op   = 1'b1;
        rem_op    = 1'b1;
      end
      rv_div_op_pkg::REMUW: begin
        word_op = 1'b1;
        rem_op  = 1'b1;
      end
      // DIVU and undefined codes divide unsigned
      default: ;
    endcase
  end

  // word ops keep the low half, sign or zero extended
  assign a_ext = word_op ? {{half{signed_op & req.dividend[half-1]}}, req.dividend[half-1:0]}
                         : req.dividend;
  assign b_ext = word_op ? {{half{signed_op & req.divisor[half-1]}}, req.divisor[half-1:0]}
                         : req.divisor;

  assign a_neg = signed_op & a_ext[xlen-1];
  assign b_neg = signed_op & b_ext[xlen-1];

  // two's-complement magnitudes; the most negative value maps onto itself
  assign cmd.dividend = a_neg ? (~a_ext + 1'b1) : a_ext;
  assign cmd.divisor  = b_neg ? (~b_ext + 1'b1) : b_ext;

  // ------------------------------------------------------------
  // sign restore flags
  // ------------------------------------------------------------
  // no quotient negate with a zero operand, so x/0 stays all ones
  assign fix.q_neg   = (a_neg ^ b_neg) & (|a_ext) & (|b_ext);
  // remainder follows the dividend
  assign fix.r_neg   = a_neg;
  assign fix.word    = word_op;
  assign fix.rem_sel = rem_op;
  assign fix.rsvd    = 2'b00;

  // start strobe and fake bypass
  assign cmd_valid = req_valid & (req.op != rv_div_op_pkg::NONE) & ~fake & ~busy;
  assign fake_ack  = req_valid & fake;

endmodule

// ==== src/div_radix4_core.sv ====
// unsigned radix-4 divider; one division at a time, data_width must be even and match dp_width
`timescale 1ns/1ps

module div_radix4_core #(
  parameter int unsigned data_width = 64
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cmd_valid,
  input  div_core_pkg::div_cmd_t      cmd,
  output logic                        busy,
  output logic                        done,
  output div_core_pkg::div_core_out_t out
);

  // two quotient bits retired per step
  localparam int unsigned steps = data_width / 2;
  localparam int unsigned cnt_w = $clog2(steps + 1);

  div_core_pkg::core_state_e state_q;
  logic [cnt_w-1:0]          cnt_q;

  // quo_q starts as the dividend and fills with digits from the bottom
  logic [data_width-1:0]     quo_q;
  logic [data_width-1:0]     rem_q;
  logic [data_width-1:0]     dsr_q;

  logic                      step_en;
  logic [data_width-1:0]     rem_src;
  logic [data_width-1:0]     dvd_src;
  logic [data_width-1:0]     dsr_src;
  logic [data_width+1:0]     shifted;
  logic [data_width+1:0]     d1;
  logic [data_width+1:0]     d2;
  logic [data_width+1:0]     d3;
  logic [data_width+1:0]     diff;
  logic [1:0]                digit;
  logic [data_width-1:0]     rem_nxt;
  logic [data_width-1:0]     quo_nxt;

  // ------------------------------------------------------------
  // one radix-4 step
  // ------------------------------------------------------------
  // the load edge already performs the first step
  assign rem_src = cmd_valid ? '0 : rem_q;
  assign dvd_src = cmd_valid ? cmd.dividend : quo_q;
  assign dsr_src = cmd_valid ? cmd.divisor : dsr_q;

  // next two dividend bits into the partial remainder
  assign shifted = {rem_src, dvd_src[data_width-1 -: 2]};

  // divisor multiples, 3x fits in two extra bits
  assign d1 = {2'b00, dsr_src};
  assign d2 = {1'b0, dsr_src, 1'b0};
  assign d3 = d1 + d2;

  // largest multiple that fits
  // zero divisor always takes digit 3 and passes the dividend through
  always_comb begin
    if (shifted >= d3) begin
      digit = 2'd3;
      diff  = shifted - d3;
    end else if (shifted >= d2) begin
      digit = 2'd2;
      diff  = shifted - d2;
    end else if (shifted >= d1) begin
      digit = 2'd1;
      diff  = shifted - d1;
    end else begin
      digit = 2'd0;
      diff  = shifted;
    end
  end

  // remainder stays below the divisor, top bits drop out
  assign rem_nxt = diff[data_width-1:0];
  assign quo_nxt = {dvd_src[data_width-3:0], digit};

  // ------------------------------------------------------------
  // sequencing
  // ------------------------------------------------------------
  // cnt_q counts steps already done
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= div_core_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        div_core_pkg::IDLE: begin
          if (cmd_valid) begin
            state_q <= div_core_pkg::RUN;
            cnt_q   <= cnt_w'(1);
          end
        end
        div_core_pkg::RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == cnt_w'(steps - 1)) begin
            state_q <= div_core_pkg::DONE;
          end
        end
        div_core_pkg::DONE: begin
          state_q <= div_core_pkg::IDLE;
        end
        default: state_q <= div_core_pkg::IDLE;
      endcase
    end
  end

  assign step_en = cmd_valid | (state_q == div_core_pkg::RUN);

  // datapath registers
  always_ff @(posedge clk) begin
    if (step_en) begin
      quo_q <= quo_nxt;
      rem_q <= rem_nxt;
      dsr_q <= dsr_src;
    end
  end

  assign busy = (state_q != div_core_pkg::IDLE);
  assign done = (state_q == div_core_pkg::DONE);

  // valid only while done is high
  assign out.quotient  = quo_q;
  assign out.remainder = rem_q;

endmodule

// ==== src/div_result_fixup.sv ====
// sign restore and word extension; flags are taken at acceptance, one division in flight
`timescale 1ns/1ps

module div_result_fixup (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cmd_valid,
  input  rv_div_op_pkg::div_fix_t     fix_in,
  input  logic                        done,
  input  div_core_pkg::div_core_out_t core_out,
  output logic                        resp_valid,
  output rv_div_op_pkg::div_resp_t    resp
);

  localparam int unsigned xlen = rv_div_op_pkg::xlen;
  localparam int unsigned half = rv_div_op_pkg::half;

  rv_div_op_pkg::div_fix_t  fix_q;
  logic [xlen-1:0]          quo_s;
  logic [xlen-1:0]          rem_s;
  rv_div_op_pkg::div_word_u sel;
  rv_div_op_pkg::div_word_u res;

  // flags of the division in flight
  always_ff @(posedge clk) begin
    if (reset) begin
      fix_q <= '0;
    end else if (cmd_valid) begin
      fix_q <= fix_in;
    end
  end

  // ------------------------------------------------------------
  // sign restore and select
  // ------------------------------------------------------------
  assign quo_s = fix_q.q_neg ? (~core_out.quotient + 1'b1) : core_out.quotient;
  assign rem_s = fix_q.r_neg ? (~core_out.remainder + 1'b1) : core_out.remainder;

  assign sel.d = fix_q.rem_sel ? rem_s : quo_s;

  // word ops read the low-word view and sign-extend it
  always_comb begin
    if (fix_q.word) begin
      res.w.hi = {half{sel.w.lo[half-1]}};
      res.w.lo = sel.w.lo;
    end else begin
      res.d = sel.d;
    end
  end

  // ------------------------------------------------------------
  // response register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= done;
    end
  end

  // held until the next result
  always_ff @(posedge clk) begin
    if (done) begin
      resp.result <= res;
    end
  end

endmodule

// ==== src/div_unit.sv ====
// RV64 divide unit; no back-pressure, watch busy, a request while busy gets no response
`timescale 1ns/1ps

module div_unit #(
  parameter int unsigned data_width = rv_div_op_pkg::xlen
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_valid,
  input  rv_div_op_pkg::div_req_t  req,
  input  logic                     fake,
  output logic                     busy,
  output logic                     resp_valid,
  output rv_div_op_pkg::div_resp_t resp,
  output logic                     fake_ack
);

  // ------------------------------------------------------------
  // internal links
  // ------------------------------------------------------------
  logic                        cmd_valid;
  div_core_pkg::div_cmd_t      cmd;
  rv_div_op_pkg::div_fix_t     fix;
  logic                        core_done;
  div_core_pkg::div_core_out_t core_out;

  // decode, magnitudes, fake bypass
  div_operand_prep u_prep (
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .fake      (fake),
    .busy      (busy),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .fix       (fix),
    .fake_ack  (fake_ack)
  );

  // unsigned iterative divide
  div_radix4_core #(
    .data_width (data_width)
  ) u_core (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .busy      (busy),
    .done      (core_done),
    .out       (core_out)
  );

  // signs, word extension, response
  div_result_fixup u_fixup (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .fix_in     (fix),
    .done       (core_done),
    .core_out   (core_out),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

endmodule

// ==== src/rv_div_op_pkg.sv ====
// instruction-level divide types; RV64 only, opcode values 9 to 15 are not defined
package rv_div_op_pkg;

  // architectural register width
  localparam int unsigned xlen = 64;
  localparam int unsigned half = xlen / 2;

  // ------------------------------------------------------------
  // opcode encoding, as driven by decode
  // ------------------------------------------------------------
  typedef enum logic [3:0] {
    NONE  = 4'd0,
    DIV   = 4'd1,
    DIVU  = 4'd2,
    REM   = 4'd3,
    REMU  = 4'd4,
    DIVW  = 4'd5,
    DIVUW = 4'd6,
    REMW  = 4'd7,
    REMUW = 4'd8
  } div_op_e;

  // request payload, rs1 is the dividend and rs2 the divisor
  typedef struct packed {
    div_op_e          op;
    logic [xlen-1:0]  dividend;
    logic [xlen-1:0]  divisor;
  } div_req_t;

  // ------------------------------------------------------------
  // result word
  // ------------------------------------------------------------
  typedef struct packed {
    logic [half-1:0] hi;
    logic [half-1:0] lo;
  } div_half_t;

  // same bits seen as a doubleword or as two words
  typedef union packed {
    logic [xlen-1:0] d;
    div_half_t       w;
  } div_word_u;

  typedef struct packed {
    div_word_u result;
  } div_resp_t;

  // sign and select flags carried from prep to fixup
  typedef struct packed {
    logic       q_neg;
    logic       r_neg;
    logic       word;
    logic       rem_sel;
    // spare, kept at zero
    logic [1:0] rsvd;
  } div_fix_t;

endpackage

// ==== testbench/div_patterns.txt ====
# columns: opcode (1 DIV 2 DIVU 3 REM 4 REMU 5 DIVW 6 DIVUW 7 REMW 8 REMUW), dividend, divisor,
# expected 64-bit result, all but the opcode in hex; text after the fourth column is ignored
1 0000000000000007 0000000000000002 0000000000000003 // DIV 7 / 2
1 FFFFFFFFFFFFFFF9 0000000000000002 FFFFFFFFFFFFFFFD // DIV -7 / 2
1 0000000000000007 FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFD // DIV 7 / -2
1 FFFFFFFFFFFFFFF9 FFFFFFFFFFFFFFFE 0000000000000003 // DIV -7 / -2
1 8000000000000000 0000000000000002 C000000000000000 // DIV min / 2
3 FFFFFFFFFFFFFFF9 0000000000000002 FFFFFFFFFFFFFFFF // REM -7 % 2
3 0000000000000007 FFFFFFFFFFFFFFFE 0000000000000001 // REM 7 % -2
3 FFFFFFFFFFFFFFF9 FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFF // REM -7 % -2
2 FFFFFFFFFFFFFFF9 0000000000000002 7FFFFFFFFFFFFFFC // DIVU large / 2
4 FFFFFFFFFFFFFFF9 0000000000000002 0000000000000001 // REMU large % 2
2 0123456789ABCDEF 0000000000001000 0000123456789ABC // DIVU by 4096
4 0123456789ABCDEF 0000000000001000 0000000000000DEF // REMU by 4096
1 0000000000001234 0000000000000000 FFFFFFFFFFFFFFFF // DIV by zero
3 FFFFFFFFFFFFFFF9 0000000000000000 FFFFFFFFFFFFFFF9 // REM by zero
2 0000000000000005 0000000000000000 FFFFFFFFFFFFFFFF // DIVU by zero
4 0000000000000005 0000000000000000 0000000000000005 // REMU by zero
1 8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000 // DIV min / -1
3 8000000000000000 FFFFFFFFFFFFFFFF 0000000000000000 // REM min % -1
1 0000000000000000 FFFFFFFFFFFFFFFB 0000000000000000 // DIV 0 / -5
5 12345678FFFFFFF9 ABCDEF0000000002 FFFFFFFFFFFFFFFD // DIVW -7 / 2
7 12345678FFFFFFF9 ABCDEF0000000002 FFFFFFFFFFFFFFFF // REMW -7 % 2
6 12345678FFFFFFF9 0000000000000001 FFFFFFFFFFFFFFF9 // DIVUW bit 31 set
6 00000000FFFFFFF9 FFFFFFFF00000002 000000007FFFFFFC // DIVUW / 2
8 00000000FFFFFFF9 0000000000000010 0000000000000009 // REMUW % 16
5 0000000080000000 00000000FFFFFFFF FFFFFFFF80000000 // DIVW min / -1
7 0000000080000000 00000000FFFFFFFF 0000000000000000 // REMW min % -1
5 0000000000000064 FFFFFFFF00000000 FFFFFFFFFFFFFFFF // DIVW by zero
7 00000000FFFFFF9C 1234567800000000 FFFFFFFFFFFFFF9C // REMW by zero
8 0000000080000001 0000000000000000 FFFFFFFF80000001 // REMUW by zero
6 0000000000000064 0000000000000000 FFFFFFFFFFFFFFFF // DIVUW by zero

// ==== testbench/div_unit_properties.sv ====
// protocol checks bound into div_unit; the 33-cycle latency holds for the 64-bit build only
`timescale 1ns/1ps

module div_unit_properties (
  input logic clk,
  input logic reset,
  input logic cmd_valid,
  input logic busy,
  input logic resp_valid,
  input logic fake_ack
);

  // cycles from the accepting edge to resp_valid
  localparam int unsigned latency = 33;

  // ------------------------------------------------------------
  // response timing
  // ------------------------------------------------------------
  // every response belongs to an accept exactly latency cycles back
  resp_has_accept: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> $past(cmd_valid, latency))
    else $error("resp_valid without an accept %0d cycles earlier", latency);

  // and every accept gets its response
  accept_has_resp: assert property (@(posedge clk) disable iff (reset)
    $past(cmd_valid, latency) |-> resp_valid)
    else $error("no resp_valid %0d cycles after accept", latency);

  // single-cycle strobe
  resp_one_cycle: assert property (@(posedge clk) disable iff (reset)
    resp_valid |=> !resp_valid)
    else $error("resp_valid held longer than one cycle");

  // ------------------------------------------------------------
  // busy window
  // ------------------------------------------------------------
  busy_after_accept: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |=> busy)
    else $error("busy low right after accept");

  // busy only falls together with the response
  busy_until_resp: assert property (@(posedge clk) disable iff (reset)
    busy |=> busy || resp_valid)
    else $error("busy dropped before the response");

  busy_low_at_resp: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> !busy)
    else $error("busy still high at the response");

  // fake bypass never starts the core
  fake_no_start: assert property (@(posedge clk) disable iff (reset)
    !(fake_ack && cmd_valid))
    else $error("fake_ack together with cmd_valid");

endmodule

bind div_unit div_unit_properties u_props (
  .clk        (clk),
  .reset      (reset),
  .cmd_valid  (cmd_valid),
  .busy       (busy),
  .resp_valid (resp_valid),
  .fake_ack   (fake_ack)
);

// ==== testbench/div_unit_tb.sv ====
// testbench for div_unit; run from the project root, reads testbench/div_patterns.txt
`timescale 1ns/1ps

module div_unit_tb;

  localparam int unsigned latency = 33;
  localparam int unsigned n_rand  = 40;

  logic                     clk = 1'b0;
  logic                     reset;
  logic                     req_valid;
  rv_div_op_pkg::div_req_t  req;
  logic                     fake;
  logic                     busy;
  logic                     resp_valid;
  rv_div_op_pkg::div_resp_t resp;
  logic                     fake_ack;

  // pattern table
  rv_div_op_pkg::div_op_e pat_op[$];
  logic [63:0]            pat_a[$];
  logic [63:0]            pat_b[$];
  logic [63:0]            pat_r[$];

  int unsigned cycle_cnt   = 0;
  int unsigned cycle_limit = 0;
  int          seed;

  div_unit dut (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .fake       (fake),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp       (resp),
    .fake_ack   (fake_ack)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ------------------------------------------------------------
  // run limit
  // ------------------------------------------------------------
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $fatal(1, "cycle limit reached");
    end
  end

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_resp(input rv_div_op_pkg::div_resp_t got,
                            input rv_div_op_pkg::div_resp_t exp, input string what);
    if (got.result.d !== exp.result.d) begin
      $display("[ERROR] %0t ns: %s result %h, expected %h", $time, what,
               got.result.d, exp.result.d);
      $display("Test failed");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("[ERROR] %0t ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "latency mismatch");
    end
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  task automatic load_patterns();
    int          fd;
    int          op_num;
    string       line;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    fd = $fopen("testbench/div_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open testbench/div_patterns.txt");
      $display("Test failed");
      $fatal(1, "pattern file missing");
    end
    // header lines fail the scan and drop out
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%d %h %h %h", op_num, a, b, r) == 4) begin
          pat_op.push_back(rv_div_op_pkg::div_op_e'(op_num[3:0]));
          pat_a.push_back(a);
          pat_b.push_back(b);
          pat_r.push_back(r);
        end
      end
    end
    $fclose(fd);
  endtask

  // one-cycle strobe, fake_ack sampled mid-cycle
  task automatic send_req(input rv_div_op_pkg::div_op_e op, input logic [63:0] a,
                          input logic [63:0] b, input logic is_fake);
    @(posedge clk);
    #2;
    req_valid    = 1'b1;
    req.op       = op;
    req.dividend = a;
    req.divisor  = b;
    fake         = is_fake;
    @(negedge clk);
    check_flag(fake_ack, is_fake, "fake_ack");
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    fake      = 1'b0;
  endtask

  // counts negedges after the accepting edge, busy must hold until resp_valid
  task automatic wait_resp(input int start, output int n);
    logic seen;
    n    = start;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      n++;
      seen = resp_valid;
      if (!seen) begin
        check_flag(busy, 1'b1, "busy during division");
      end
    end
  endtask

  task automatic run_case(input rv_div_op_pkg::div_op_e op, input logic [63:0] a,
                          input logic [63:0] b, input logic [63:0] expected);
    rv_div_op_pkg::div_resp_t exp_resp;
    int                       n;
    string                    what;
    what = $sformatf("%s %h %h", op.name(), a, b);
    exp_resp.result.d = expected;
    send_req(op, a, b, 1'b0);
    wait_resp(0, n);
    check_count(n, latency, what);
    check_resp(resp, exp_resp, what);
    check_flag(busy, 1'b0, "busy at response");
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin : main
    logic [63:0]              a;
    logic [63:0]              b;
    int                       sh;
    int                       n;
    rv_div_op_pkg::div_resp_t exp_resp;
    reset     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    fake      = 1'b0;
    seed      = 32'he85f_a338;
    load_patterns();
    if (pat_op.size() == 0) begin
      $display("no patterns found in testbench/div_patterns.txt");
      $display("Test failed");
      $fatal(1, "empty pattern file");
    end
    cycle_limit = (pat_op.size() + n_rand + 5) * 40;

    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    // table cases, signed, unsigned, word and corners
    for (int i = 0; i < pat_op.size(); i++) begin
      run_case(pat_op[i], pat_a[i], pat_b[i], pat_r[i]);
    end

    // fake bypass, ack at once and nothing else
    send_req(rv_div_op_pkg::DIV, 64'd7, 64'd2, 1'b1);
    repeat (latency + 5) begin
      @(negedge clk);
      check_flag(resp_valid, 1'b0, "resp_valid after fake");
      check_flag(busy, 1'b0, "busy after fake");
    end

    // second request while busy, dropped
    @(posedge clk);
    #2;
    req_valid    = 1'b1;
    req.op       = rv_div_op_pkg::DIVU;
    req.dividend = 64'd100;
    req.divisor  = 64'd7;
    @(posedge clk);
    #2;
    req.dividend = 64'd500;
    req.divisor  = 64'd3;
    @(negedge clk);
    check_flag(busy, 1'b1, "busy after accept");
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    wait_resp(1, n);
    check_count(n, latency, "request before the dropped one");
    exp_resp.result.d = 64'd14;
    check_resp(resp, exp_resp, "DIVU 100 / 7 with a dropped request");
    repeat (latency + 7) begin
      @(negedge clk);
      check_flag(resp_valid, 1'b0, "resp_valid for dropped request");
    end

    // random unsigned, divisor scaled down for a spread of quotients
    for (int i = 0; i < n_rand; i++) begin
      a  = {$random(seed), $random(seed)};
      b  = {$random(seed), $random(seed)};
      sh = $random(seed) & 63;
      b  = b >> sh;
      if (b == 64'd0) begin
        b = 64'd1;
      end
      if (i % 2 == 0) begin
        run_case(rv_div_op_pkg::DIVU, a, b, a / b);
      end else begin
        run_case(rv_div_op_pkg::REMU, a, b, a % b);
      end
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule
